// ==== hdl/apb_fb_port.sv ====
// APB slave that turns host writes into framebuffer bytes or the control register
`timescale 1ns/100ps

module apb_fb_port (
    input logic ClockA,
    input logic reset,
    input logic psel,
    input logic penable,
    input logic pwrite,
    input logic [led_panel_pkg::apb_addr_bits-1:0] paddr,
    input logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic pready,
    output logic pslverr,
    output logic fb_wr_en,
    output led_panel_pkg::fb_write_addr_t fb_wr_addr,
    output logic [7:0] fb_wr_data,
    output logic scan_enable
);

    led_panel_pkg::apb_word_u wr_word;
    led_panel_pkg::apb_word_u rd_word;
    logic access;
    logic ctrl_hit;
    logic fb_hit;
    // top address bit set, nothing mapped there
    logic unmapped;
    logic spare_hit;
    logic enable_q;

    assign wr_word = pwdata;
    assign access = psel && penable;

    // address decode
    assign unmapped = paddr[led_panel_pkg::apb_addr_bits-1];
    assign ctrl_hit = !unmapped && paddr[led_panel_pkg::ctrl_reg_sel];
    assign fb_hit = !unmapped && !paddr[led_panel_pkg::ctrl_reg_sel];
    // framebuffer is byte addressed from paddr bit 0
    assign fb_wr_addr = paddr[$bits(led_panel_pkg::fb_write_addr_t)-1:0];
    assign spare_hit = fb_wr_addr.colour == led_panel_pkg::colour_spare;

    // one strobe per access phase, RAM registers it
    assign fb_wr_en = access && pwrite && fb_hit && !spare_hit;
    assign fb_wr_data = wr_word.pixel.value;

    always_ff @(posedge ClockA) begin
        if (reset) begin
            enable_q <= 1'b0;
        end else if (access && pwrite && ctrl_hit) begin
            enable_q <= wr_word.ctrl.enable;
        end
    end

    assign scan_enable = enable_q;

    // control readback word
    always_comb begin
        rd_word = '0;
        rd_word.ctrl.enable = enable_q;
    end

    assign prdata = (access && !pwrite && ctrl_hit) ? rd_word : 32'd0;

    // no wait states
    assign pready = access;

    // spare colour writes, framebuffer reads and the unmapped range are errors
    assign pslverr = access && (unmapped || (pwrite ? (fb_hit && spare_hit) : fb_hit));

endmodule

// ==== hdl/fb_banked_ram.sv ====
// banked framebuffer, writes one byte lane at a time and reads all eight lanes together
`timescale 1ns/100ps

module fb_banked_ram (
    input logic ClockA,
    input logic reset,
    input logic wr_en,
    input led_panel_pkg::fb_write_addr_t wr_addr,
    input logic [7:0] wr_data,
    fb_read_if.memory rd
);

    // lane picked by half and colour
    logic [led_panel_pkg::lane_bits-1:0] wr_lane;
    // per lane write strobe, one cycle after the APB strobe
    logic [led_panel_pkg::num_lanes-1:0] we_q;
    // row and column plus byte, shared by every lane
    led_panel_pkg::fb_read_addr_t wr_addr_q;
    logic [7:0] wr_data_q;
    // rd_en delayed to match the two stage lane read
    logic [1:0] valid_pipe;
    wire led_panel_pkg::fb_lane_word_t rd_word;

    assign wr_lane = {wr_addr.half, wr_addr.colour};

    always_ff @(posedge ClockA) begin
        if (reset) begin
            we_q <= '0;
        end else begin
            for (int i = 0; i < led_panel_pkg::num_lanes; i++) begin
                we_q[i] <= wr_en && (wr_lane == led_panel_pkg::lane_bits'(i));
            end
        end
    end

    // payload only, qualified by we_q
    always_ff @(posedge ClockA) begin
        wr_addr_q <= {wr_addr.row, wr_addr.col};
        wr_data_q <= wr_data;
    end

    always_ff @(posedge ClockA) begin
        if (reset) begin
            valid_pipe <= 2'b00;
        end else begin
            valid_pipe <= {valid_pipe[0], rd.rd_en};
        end
    end

    for (genvar i = 0; i < led_panel_pkg::num_lanes; i++) begin : g_lane
        fb_lane u_lane (
            .ClockA (ClockA),
            .wr_en  (we_q[i]),
            .wr_addr(wr_addr_q),
            .wr_data(wr_data_q),
            .rd_en  (rd.rd_en),
            .rd_addr(rd.rd_addr),
            // lane i lands in byte i of the word
            .rd_data(rd_word[i*8 +: 8])
        );
    end

    assign rd.rd_data = rd_word;
    assign rd.rd_valid = valid_pipe[1];

endmodule

// ==== hdl/fb_lane.sv ====
// framebuffer lane, a 256 byte RAM with registered write and two stage read
`timescale 1ns/100ps

module fb_lane (
    input logic ClockA,
    input logic wr_en,
    input led_panel_pkg::fb_read_addr_t wr_addr,
    input logic [7:0] wr_data,
    input logic rd_en,
    input led_panel_pkg::fb_read_addr_t rd_addr,
    output logic [7:0] rd_data
);

    logic [7:0] mem [0:(1 << $bits(led_panel_pkg::fb_read_addr_t))-1];
    // first read stage, straight out of the array
    logic [7:0] mem_q;

    always_ff @(posedge ClockA) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        // read before write on a collision
        if (rd_en) begin
            mem_q <= mem[rd_addr];
        end
        // output register, second cycle of the read
        rd_data <= mem_q;
    end

endmodule

// ==== hdl/fb_read_if.sv ====
// framebuffer read port shared by the scan controller, the banked RAM and the pixel shifter
`timescale 1ns/100ps

interface fb_read_if;

    // one read every second cycle, data two cycles after rd_en
    logic rd_en;
    led_panel_pkg::fb_read_addr_t rd_addr;
    // all eight lanes side by side
    led_panel_pkg::fb_lane_word_t rd_data;
    logic rd_valid;

    // scan controller issues the reads
    modport requester (
        output rd_en,
        output rd_addr
    );

    // RAM answers
    modport memory (
        input rd_en,
        input rd_addr,
        output rd_data,
        output rd_valid
    );

    // shifter only looks at returned data
    modport consumer (
        input rd_data,
        input rd_valid
    );

endinterface

// ==== hdl/led_panel_pkg.sv ====
// led panel package with panel geometry, framebuffer address layouts and the APB data word
package led_panel_pkg;

    // panel geometry, 32x16 split into two halves at 1/8 scan
    localparam int panel_cols = 32;
    localparam int scan_rows = 8;
    localparam int bit_planes = 8;

    // address field widths
    localparam int col_bits = 5;
    localparam int row_bits = 3;
    localparam int plane_bits = 3;
    localparam int lane_bits = 3;
    // lane index is {half, colour}
    localparam int num_lanes = 8;

    // scan timing, plane p is shown for oe_base << p cycles
    localparam int timer_bits = 10;
    localparam logic [timer_bits-1:0] oe_base = 4;
    // four idle cycles between the last column read data and latch
    localparam logic [timer_bits-1:0] settle_last = 3;

    localparam logic [col_bits-1:0] last_col = col_bits'(panel_cols - 1);
    localparam logic [row_bits-1:0] last_row = row_bits'(scan_rows - 1);
    localparam logic [plane_bits-1:0] last_plane = plane_bits'(bit_planes - 1);

    // colour codes inside a half
    localparam logic [1:0] colour_r = 2'd0;
    localparam logic [1:0] colour_g = 2'd1;
    localparam logic [1:0] colour_b = 2'd2;
    localparam logic [1:0] colour_spare = 2'd3;

    // APB map: paddr[12:11] 00 is the framebuffer, 01 the control register
    localparam int apb_addr_bits = 13;
    localparam int ctrl_reg_sel = 11;

    // scan FSM state codes
    localparam logic [2:0] scan_idle = 3'd0;
    localparam logic [2:0] scan_shift = 3'd1;
    localparam logic [2:0] scan_settle = 3'd2;
    localparam logic [2:0] scan_latch = 3'd3;
    localparam logic [2:0] scan_display = 3'd4;

    // read address shared by all lanes
    typedef struct packed {
        logic [row_bits-1:0] row;
        logic [col_bits-1:0] col;
    } fb_read_addr_t;

    // byte address of one colour of one pixel
    typedef struct packed {
        logic [row_bits-1:0] row;
        logic [col_bits-1:0] col;
        logic half;
        logic [1:0] colour;
    } fb_write_addr_t;

    // lane i sits in byte i
    typedef logic [num_lanes*8-1:0] fb_lane_word_t;

    // pwdata seen either as a pixel byte or as the control word
    typedef union packed {
        struct packed {
            logic [23:0] reserved;
            logic [7:0] value;
        } pixel;
        struct packed {
            logic [30:0] reserved;
            logic enable;
        } ctrl;
    } apb_word_u;

endpackage

// ==== hdl/led_panel_top.sv ====
// LED matrix panel driver top, APB framebuffer plus scan and shift path
`timescale 1ns/100ps

module led_panel_top (
    input logic ClockA,
    input logic reset,
    // APB slave
    input logic psel,
    input logic penable,
    input logic pwrite,
    input logic [led_panel_pkg::apb_addr_bits-1:0] paddr,
    input logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic pready,
    output logic pslverr,
    // panel pins
    output logic r0,
    output logic g0,
    output logic b0,
    output logic r1,
    output logic g1,
    output logic b1,
    output logic panel_clk,
    output logic latch,
    output logic oe_n,
    output logic [led_panel_pkg::row_bits-1:0] row_sel
);

    logic fb_wr_en;
    led_panel_pkg::fb_write_addr_t fb_wr_addr;
    logic [7:0] fb_wr_data;
    logic scan_enable;
    logic [led_panel_pkg::plane_bits-1:0] plane;

    fb_read_if fb_rd ();

    apb_fb_port u_apb (
        .ClockA     (ClockA),
        .reset      (reset),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .fb_wr_en   (fb_wr_en),
        .fb_wr_addr (fb_wr_addr),
        .fb_wr_data (fb_wr_data),
        .scan_enable(scan_enable)
    );

    fb_banked_ram u_ram (
        .ClockA (ClockA),
        .reset  (reset),
        .wr_en  (fb_wr_en),
        .wr_addr(fb_wr_addr),
        .wr_data(fb_wr_data),
        .rd     (fb_rd.memory)
    );

    scan_ctrl u_scan (
        .ClockA     (ClockA),
        .reset      (reset),
        .scan_enable(scan_enable),
        .rd         (fb_rd.requester),
        .plane      (plane),
        .row_sel    (row_sel),
        .latch      (latch),
        .oe_n       (oe_n)
    );

    pixel_shifter u_shift (
        .ClockA   (ClockA),
        .reset    (reset),
        .rd       (fb_rd.consumer),
        .plane    (plane),
        .r0       (r0),
        .g0       (g0),
        .b0       (b0),
        .r1       (r1),
        .g1       (g1),
        .b1       (b1),
        .panel_clk(panel_clk)
    );

endmodule

// ==== hdl/pixel_shifter.sv ====
// pixel shifter picking the plane bit of each colour lane and clocking it into the panel
`timescale 1ns/100ps

module pixel_shifter (
    input logic ClockA,
    input logic reset,
    fb_read_if.consumer rd,
    input logic [led_panel_pkg::plane_bits-1:0] plane,
    output logic r0,
    output logic g0,
    output logic b0,
    output logic r1,
    output logic g1,
    output logic b1,
    output logic panel_clk
);

    // data on the pins for one cycle before panel_clk
    logic data_new_q;

    // bit index into the lane word is {half, colour, plane}
    always_ff @(posedge ClockA) begin
        if (reset) begin
            r0 <= 1'b0;
            g0 <= 1'b0;
            b0 <= 1'b0;
            r1 <= 1'b0;
            g1 <= 1'b0;
            b1 <= 1'b0;
        end else if (rd.rd_valid) begin
            // upper half
            r0 <= rd.rd_data[{1'b0, led_panel_pkg::colour_r, plane}];
            g0 <= rd.rd_data[{1'b0, led_panel_pkg::colour_g, plane}];
            b0 <= rd.rd_data[{1'b0, led_panel_pkg::colour_b, plane}];
            // lower half
            r1 <= rd.rd_data[{1'b1, led_panel_pkg::colour_r, plane}];
            g1 <= rd.rd_data[{1'b1, led_panel_pkg::colour_g, plane}];
            b1 <= rd.rd_data[{1'b1, led_panel_pkg::colour_b, plane}];
        end
    end

    // rising panel_clk while the data pins are stable
    always_ff @(posedge ClockA) begin
        if (reset) begin
            data_new_q <= 1'b0;
            panel_clk <= 1'b0;
        end else begin
            data_new_q <= rd.rd_valid;
            panel_clk <= data_new_q;
        end
    end

endmodule

// ==== hdl/scan_ctrl.sv ====
// scan controller FSM walking rows and bit planes with binary coded modulation
`timescale 1ns/100ps

module scan_ctrl (
    input logic ClockA,
    input logic reset,
    input logic scan_enable,
    fb_read_if.requester rd,
    output logic [led_panel_pkg::plane_bits-1:0] plane,
    output logic [led_panel_pkg::row_bits-1:0] row_sel,
    output logic latch,
    output logic oe_n
);

    logic [2:0] state_q;
    logic [2:0] state_d;
    logic [led_panel_pkg::col_bits-1:0] col_q;
    // reads go out on phase 0 only
    logic phase_q;
    logic [led_panel_pkg::plane_bits-1:0] plane_q;
    logic [led_panel_pkg::row_bits-1:0] row_q;
    // settle and display cycle count
    logic [led_panel_pkg::timer_bits-1:0] timer_q;
    logic [led_panel_pkg::timer_bits-1:0] disp_last;
    logic frame_last;

    // plane p is lit for oe_base << p cycles
    assign disp_last = (led_panel_pkg::oe_base << plane_q) - 1'b1;
    assign frame_last = (plane_q == led_panel_pkg::last_plane) &&
                        (row_q == led_panel_pkg::last_row);

    always_comb begin
        state_d = state_q;
        case (state_q)
            // enable only looked at here, so a started frame always finishes
            led_panel_pkg::scan_idle: begin
                if (scan_enable) begin
                    state_d = led_panel_pkg::scan_shift;
                end
            end
            led_panel_pkg::scan_shift: begin
                if (phase_q && col_q == led_panel_pkg::last_col) begin
                    state_d = led_panel_pkg::scan_settle;
                end
            end
            // let the last column drain through RAM and shifter
            led_panel_pkg::scan_settle: begin
                if (timer_q == led_panel_pkg::settle_last) begin
                    state_d = led_panel_pkg::scan_latch;
                end
            end
            led_panel_pkg::scan_latch: begin
                state_d = led_panel_pkg::scan_display;
            end
            led_panel_pkg::scan_display: begin
                if (timer_q == disp_last) begin
                    state_d = frame_last ? led_panel_pkg::scan_idle : led_panel_pkg::scan_shift;
                end
            end
            default: begin
                state_d = led_panel_pkg::scan_idle;
            end
        endcase
    end

    always_ff @(posedge ClockA) begin
        if (reset) begin
            state_q <= led_panel_pkg::scan_idle;
            col_q <= '0;
            phase_q <= 1'b0;
            plane_q <= '0;
            row_q <= '0;
            timer_q <= '0;
            row_sel <= '0;
            latch <= 1'b0;
            oe_n <= 1'b1;
        end else begin
            state_q <= state_d;
            // panel strobes registered from the next state, aligned with it
            latch <= state_d == led_panel_pkg::scan_latch;
            oe_n <= state_d != led_panel_pkg::scan_display;
            // col wraps back to 0 after the last column
            if (state_q == led_panel_pkg::scan_shift) begin
                phase_q <= !phase_q;
                if (phase_q) begin
                    col_q <= col_q + 1'b1;
                end
            end
            // restart the timer on every state change
            if (state_d != state_q) begin
                timer_q <= '0;
            end else begin
                timer_q <= timer_q + 1'b1;
            end
            // row drivers switch together with latch
            if (state_d == led_panel_pkg::scan_latch) begin
                row_sel <= row_q;
            end
            // next plane, next row after plane 7
            if (state_q == led_panel_pkg::scan_display &&
                state_d != led_panel_pkg::scan_display) begin
                plane_q <= plane_q + 1'b1;
                if (plane_q == led_panel_pkg::last_plane) begin
                    row_q <= row_q + 1'b1;
                end
            end
        end
    end

    assign rd.rd_en = (state_q == led_panel_pkg::scan_shift) && !phase_q;
    assign rd.rd_addr = {row_q, col_q};
    assign plane = plane_q;

endmodule

// ==== led_panel_top.f ====
hdl/led_panel_pkg.sv
hdl/fb_read_if.sv
hdl/fb_lane.sv
hdl/fb_banked_ram.sv
hdl/apb_fb_port.sv
hdl/scan_ctrl.sv
hdl/pixel_shifter.sv
hdl/led_panel_top.sv
verif/led_panel_sva.sv
verif/led_panel_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the LED panel testbench with Verilator, run it and scan the log
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module led_panel_tb -f led_panel_top.f \
    -o led_panel_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/led_panel_sim > sim.log 2>&1
grep -q "TEST FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "TEST PASSED" sim.log || { echo "simulation ended without a result, see sim.log"; exit 1; }
echo "simulation passed"
exit 0

// ==== verif/led_panel_sva.sv ====
// protocol assertions for the LED panel driver, APB handshake and panel strobes
`timescale 1ns/100ps

module led_panel_sva (
    input logic ClockA,
    input logic reset,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic oe_n,
    input logic latch,
    input logic panel_clk
);

    // rows stay dark while the shift register or the latch moves
    a_dark_on_strobe: assert property (
        @(posedge ClockA) disable iff (reset) !oe_n |-> !(latch || panel_clk)
    ) else $error("oe_n low together with latch or panel_clk");

    // no wait states, every access phase completes at once
    a_pready_in_access: assert property (
        @(posedge ClockA) disable iff (reset) (psel && penable) |-> pready
    ) else $error("pready missing in an APB access phase");

    // one column per panel_clk pulse
    a_single_clk_pulse: assert property (
        @(posedge ClockA) disable iff (reset) panel_clk |=> !panel_clk
    ) else $error("panel_clk high on two consecutive cycles");

endmodule

// ==== verif/led_panel_tb.sv ====
// testbench for the LED panel driver with APB fill, random pixels and a scan monitor
`timescale 1ns/100ps

module led_panel_tb;

    // control register selected by paddr bit 11 with framebuffer bytes below it
    localparam logic [12:0] ctrl_addr = 13'h0800;
    localparam int apb_timeout = 16;
    // a frame is about 12600 cycles
    localparam int frame_timeout = 40000;
    localparam int num_bytes = 2048;

    logic ClockA = 1'b0;
    logic reset;
    logic psel;
    logic penable;
    logic pwrite;
    logic [12:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;
    logic r0;
    logic g0;
    logic b0;
    logic r1;
    logic g1;
    logic b1;
    logic panel_clk;
    logic latch;
    logic oe_n;
    logic [2:0] row_sel;
    logic [5:0] panel_data;

    // expected framebuffer indexed as {row, col, half, colour}
    logic [7:0] ref_mem [0:num_bytes-1];
    // byte is compared again once frames_done reaches this count
    int dirty_until [0:num_bytes-1];
    logic [31:0] lfsr_state;

    // monitor position in the scan
    int col_cnt;
    int mon_plane;
    int mon_row;
    int oe_count;
    int frame_latches;
    int frames_done;
    logic in_display;

    assign panel_data = {r0, g0, b0, r1, g1, b1};

    always #2 ClockA = ~ClockA;

    led_panel_top led_panel_top_i (.*);

    bind led_panel_top led_panel_sva led_panel_sva_i (
        .ClockA   (ClockA),
        .reset    (reset),
        .psel     (psel),
        .penable  (penable),
        .pready   (pready),
        .oe_n     (oe_n),
        .latch    (latch),
        .panel_clk(panel_clk)
    );

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic int byte_index(input int row, input int col, input int half,
                                      input int colour);
        return (row * 256) + (col * 8) + (half * 4) + colour;
    endfunction

    // reference model with bits in pin order r0 g0 b0 r1 g1 b1
    function automatic logic [5:0] expected_bits(input int row, input int col, input int plane);
        logic [5:0] bits;
        for (int half = 0; half < 2; half++) begin
            for (int colour = 0; colour < 3; colour++) begin
                bits[5 - (half * 3 + colour)] = ref_mem[byte_index(row, col, half, colour)][plane];
            end
        end
        return bits;
    endfunction

    // column holds a byte rewritten in the frame being shown
    function automatic logic column_dirty(input int row, input int col);
        logic dirty;
        dirty = 1'b0;
        for (int half = 0; half < 2; half++) begin
            for (int colour = 0; colour < 3; colour++) begin
                if (frames_done < dirty_until[byte_index(row, col, half, colour)]) begin
                    dirty = 1'b1;
                end
            end
        end
        return dirty;
    endfunction

    task automatic random_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic stop_on_error(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_on_error($sformatf("[FAIL] %0d ns: %s, got 0x%0h, expected 0x%0h",
                                    $time, what, actual, expected));
        end
    endtask

    // setup phase, access phase, then back to idle
    task automatic apb_transfer(input logic write, input logic [12:0] addr,
                                input logic [31:0] data, input logic exp_err,
                                output logic [31:0] rdata);
        int cycles;
        @(posedge ClockA);
        #1;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = write;
        paddr = addr;
        pwdata = data;
        @(posedge ClockA);
        #1;
        penable = 1'b1;
        cycles = 0;
        @(negedge ClockA);
        while (!pready) begin
            cycles++;
            if (cycles > apb_timeout) begin
                stop_on_error("timeout waiting for pready on an APB transfer");
            end
            @(negedge ClockA);
        end
        check_value("pslverr", 32'(pslverr), 32'(exp_err));
        rdata = prdata;
        @(posedge ClockA);
        #1;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [12:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] unused;
        apb_transfer(1'b1, addr, data, exp_err, unused);
    endtask

    task automatic apb_read(input logic [12:0] addr, input logic exp_err,
                            output logic [31:0] rdata);
        apb_transfer(1'b0, addr, 32'd0, exp_err, rdata);
    endtask

    task automatic wait_frames(input int target);
        int cycles;
        cycles = 0;
        while (frames_done < target) begin
            @(posedge ClockA);
            cycles++;
            if (cycles > frame_timeout) begin
                stop_on_error("timeout waiting for a frame to complete");
            end
        end
    endtask

    task automatic wait_row(input int row);
        int cycles;
        cycles = 0;
        while (mon_row != row) begin
            @(posedge ClockA);
            cycles++;
            if (cycles > frame_timeout) begin
                stop_on_error("timeout waiting for the scan to reach a row");
            end
        end
    endtask

    // panel dark and quiet with data pins checked only before the first frame
    task automatic check_idle(input int cycles, input logic with_data);
        repeat (cycles) begin
            @(negedge ClockA);
            check_value("oe_n, latch, panel_clk while idle", 32'({oe_n, latch, panel_clk}), 32'd4);
            if (with_data) begin
                check_value("panel data while idle", 32'(panel_data), 32'd0);
                check_value("row_sel while idle", 32'(row_sel), 32'd0);
            end
        end
    endtask

    // scan monitor sampled mid cycle where every output is settled
    always @(negedge ClockA) begin
        if (reset) begin
            col_cnt = 0;
            mon_plane = 0;
            mon_row = 0;
            oe_count = 0;
            frame_latches = 0;
            frames_done = 0;
            in_display = 1'b0;
        end else begin
            if (panel_clk) begin
                if (!column_dirty(mon_row, col_cnt)) begin
                    check_value("panel data bits", 32'(panel_data),
                                32'(expected_bits(mon_row, col_cnt, mon_plane)));
                end
                col_cnt++;
            end
            if (in_display) begin
                if (!oe_n) begin
                    oe_count++;
                end else begin
                    // plane p lit for oe_base << p cycles
                    check_value("oe_n low cycles", oe_count,
                                32'(led_panel_pkg::oe_base) << mon_plane);
                    in_display = 1'b0;
                    mon_plane++;
                    if (mon_plane == led_panel_pkg::bit_planes) begin
                        mon_plane = 0;
                        mon_row++;
                    end
                    if (mon_row == led_panel_pkg::scan_rows) begin
                        mon_row = 0;
                        check_value("latches per frame", frame_latches, 64);
                        frame_latches = 0;
                        frames_done++;
                    end
                end
            end else begin
                check_value("oe_n outside display", 32'(oe_n), 32'd1);
            end
            if (latch) begin
                check_value("columns shifted before latch", col_cnt, led_panel_pkg::panel_cols);
                check_value("row_sel at latch", 32'(row_sel), mon_row);
                col_cnt = 0;
                oe_count = 0;
                in_display = 1'b1;
                frame_latches++;
            end
        end
    end

    initial begin
        logic [31:0] rnd;
        logic [31:0] rdata;
        int idx;
        int frame_mark;
        reset = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        lfsr_state = 32'h4bce_f933;
        for (int i = 0; i < num_bytes; i++) begin
            dirty_until[i] = 0;
            ref_mem[i] = 8'h00;
        end
        repeat (8) @(posedge ClockA);
        #1;
        reset = 1'b0;

        // nothing moves while enable is clear
        check_idle(200, 1'b1);
        apb_write(ctrl_addr, 32'd0, 1'b0);
        apb_read(ctrl_addr, 1'b0, rdata);
        check_value("control readback", rdata, 32'd0);

        // fill all three colours of every pixel
        for (int row = 0; row < led_panel_pkg::scan_rows; row++) begin
            for (int col = 0; col < led_panel_pkg::panel_cols; col++) begin
                for (int half = 0; half < 2; half++) begin
                    for (int colour = 0; colour < 3; colour++) begin
                        random_bits(8, rnd);
                        idx = byte_index(row, col, half, colour);
                        ref_mem[idx] = rnd[7:0];
                        apb_write(13'(idx), rnd, 1'b0);
                    end
                end
            end
        end

        // spare slot write is rejected and stores nothing
        apb_write(13'(byte_index(3, 17, 1, 3)), 32'h0000_00ff, 1'b1);
        // framebuffer reads are errors
        apb_read(13'(byte_index(3, 17, 1, 0)), 1'b1, rdata);
        check_value("prdata on framebuffer read", rdata, 32'd0);

        apb_write(ctrl_addr, 32'd1, 1'b0);
        apb_read(ctrl_addr, 1'b0, rdata);
        check_value("control readback", rdata, 32'd1);
        wait_frames(1);

        // rewrite pixels mid frame and mask them until the frame ends
        wait_row(4);
        frame_mark = frames_done;
        for (int n = 0; n < 16; n++) begin
            random_bits(11, rnd);
            idx = int'(rnd);
            // fold the spare colour onto red
            if (idx % 4 == 3) begin
                idx = idx - 3;
            end
            random_bits(8, rnd);
            ref_mem[idx] = rnd[7:0];
            dirty_until[idx] = frame_mark + 1;
            apb_write(13'(idx), rnd, 1'b0);
        end
        wait_frames(frame_mark + 2);

        // disable mid frame and let the frame run to its end
        wait_row(3);
        frame_mark = frames_done;
        apb_write(ctrl_addr, 32'd0, 1'b0);
        wait_frames(frame_mark + 1);
        check_idle(500, 1'b0);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule
